// ==== dv/rf_core_vectors.svh ====
// Stimulus tables for the register subsystem testbench, debug seed registers and program
`ifndef RF_CORE_VECTORS_SVH
`define RF_CORE_VECTORS_SVH

// Registers written through the debug port, values come from the xorshift stream
localparam int N_SEEDS = 16;
localparam logic [N_SEEDS*ADDR_W-1:0] SEED_ADDRS = {
    5'd1, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd7, 5'd0,
    5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15
};

// Columns: test number, opcode, rd, rs1, rs2
localparam int N_PROG = 17;
localparam logic [N_PROG*VEC_W-1:0] PROG = {
    {3'd3, OP_ADD, 5'd16, 5'd1,  5'd2},
    {3'd3, OP_SUB, 5'd17, 5'd16, 5'd3},     // Back-to-back RAW
    {3'd3, OP_XOR, 5'd18, 5'd17, 5'd16},
    {3'd3, OP_ADD, 5'd16, 5'd18, 5'd4},
    {3'd3, OP_SUB, 5'd19, 5'd16, 5'd16},
    {3'd3, OP_XOR, 5'd20, 5'd19, 5'd5},
    {3'd4, OP_MUL, 5'd21, 5'd1,  5'd2},
    {3'd4, OP_MUL, 5'd22, 5'd3,  5'd4},
    {3'd4, OP_MUL, 5'd23, 5'd21, 5'd22},    // Waits on both products
    {3'd4, OP_ADD, 5'd24, 5'd23, 5'd6},
    {3'd4, OP_MUL, 5'd25, 5'd7,  5'd0},
    {3'd5, OP_MUL, 5'd26, 5'd8,  5'd9},
    {3'd5, OP_ADD, 5'd26, 5'd10, 5'd11},    // Overtakes the multiply
    {3'd5, OP_MUL, 5'd27, 5'd12, 5'd13},
    {3'd5, OP_XOR, 5'd27, 5'd14, 5'd15},
    {3'd5, OP_ADD, 5'd28, 5'd26, 5'd27},
    {3'd5, OP_ADD, 5'd0,  5'd1,  5'd2}
};

`endif

// ==== dv/rf_core_tb.sv ====
// Testbench for the register subsystem with debug seeding, program checks and handshake monitors
`timescale 1ns/100ps
`default_nettype none

module rf_core_tb;
    import rf_pkg::*;

    localparam int MUL_LATENCY = 6;
    localparam int ADDR_W      = $bits(reg_addr_t);

    typedef struct packed {
        logic [2:0] test;
        instr_t     instr;
    } vec_t;

    localparam int VEC_W = $bits(vec_t);

    `include "rf_core_vectors.svh"

    localparam int MAX_CYCLES = 60 * (N_SEEDS + N_PROG) + 200;

    // Write-back the model expects, with the cycle it should appear in
    typedef struct packed {
        int        due;
        reg_addr_t rd;
        reg_tag_t  tag;
        logic      is_mul;
    } wb_exp_t;

    logic      i_clk;
    logic      i_nrst;
    logic      i_req;
    instr_t    i_instr;
    logic      i_dbg_req;
    dbg_req_t  i_dbg;
    logic      o_ack;
    logic      o_dbg_ack;
    xlen_t     o_dbg_rdata;
    logic      o_wb_valid;
    reg_addr_t o_wb_rd;
    logic      o_wb_ignored;

    xlen_t       shadow [NREGS];                // Program-order register values
    reg_tag_t    issued_tag [NREGS];
    reg_tag_t    stored_tag [NREGS];            // Tags the bank should hold
    wb_exp_t     alu_q [$];
    wb_exp_t     mul_q [$];
    int          cycle;
    int          err_count;
    int          hs_errs;
    int          ignored_seen;
    int          tests_run;
    int          tests_failed;
    logic        ack_q;
    logic        dbg_ack_q;
    logic [31:0] rng;

    rf_core #(
        .MUL_LATENCY(MUL_LATENCY)
    ) UUT (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req        (i_req),
        .i_instr      (i_instr),
        .i_dbg_req    (i_dbg_req),
        .i_dbg        (i_dbg),
        .o_ack        (o_ack),
        .o_dbg_ack    (o_dbg_ack),
        .o_dbg_rdata  (o_dbg_rdata),
        .o_wb_valid   (o_wb_valid),
        .o_wb_rd      (o_wb_rd),
        .o_wb_ignored (o_wb_ignored)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic vec_t prog_entry(input int i);
        return PROG[(N_PROG-1-i)*VEC_W +: VEC_W];
    endfunction

    function automatic reg_addr_t seed_addr(input int i);
        return SEED_ADDRS[(N_SEEDS-1-i)*ADDR_W +: ADDR_W];
    endfunction

    function automatic string test_name(input int num);
        case (num)
            3:       return "ALU chains";
            4:       return "multiply";
            default: return "multiply overtaken by ALU";
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        err_count++;
        $display("Error at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic report_failure(input string msg);
        err_count++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    task automatic finish_test(input int num, input string name, input int errs);
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", num, name, errs);
        end
    endtask

    // Four-phase rules and the write-back tag model checked mid-cycle
    always @(negedge i_clk) begin
        wb_exp_t  cur;
        reg_tag_t next_tag;
        logic     alu_due;
        logic     mul_due;
        logic     exp_ign;
        if (i_nrst) begin
            if (!ack_q && o_ack && !i_req) begin
                hs_errs++;
                report_failure("o_ack rose while i_req was low");
            end
            if (ack_q && (o_ack != i_req)) begin
                hs_errs++;
                report_mismatch("o_ack", i_req, o_ack);
            end
            if (!dbg_ack_q && o_dbg_ack && !i_dbg_req) begin
                hs_errs++;
                report_failure("o_dbg_ack rose while i_dbg_req was low");
            end
            if (dbg_ack_q && (o_dbg_ack != i_dbg_req)) begin
                hs_errs++;
                report_mismatch("o_dbg_ack", i_dbg_req, o_dbg_ack);
            end
            alu_due = (alu_q.size() > 0) && (alu_q[0].due == cycle);
            mul_due = (mul_q.size() > 0) && (mul_q[0].due == cycle);
            exp_ign = 1'b0;
            if (alu_due && mul_due) begin
                report_failure("ALU and multiply write-backs due in the same cycle");
                void'(mul_q.pop_front());
            end
            if (alu_due || mul_due) begin
                cur      = alu_due ? alu_q.pop_front() : mul_q.pop_front();
                next_tag = stored_tag[cur.rd] + 1'b1;
                if (cur.rd != '0) begin
                    if (!cur.is_mul || (cur.tag == next_tag)) begin
                        stored_tag[cur.rd] = cur.tag;
                    end else begin
                        exp_ign = 1'b1;             // Stale multiply
                    end
                end
                if (o_wb_valid !== 1'b1) begin
                    report_mismatch("o_wb_valid", 1, o_wb_valid);
                end
                if (o_wb_rd !== cur.rd) begin
                    report_mismatch("o_wb_rd", cur.rd, o_wb_rd);
                end
            end else if (o_wb_valid !== 1'b0) begin
                report_mismatch("o_wb_valid", 0, o_wb_valid);
            end
            if (o_wb_ignored !== exp_ign) begin
                report_mismatch("o_wb_ignored", exp_ign, o_wb_ignored);
            end
            if (o_wb_ignored === 1'b1) begin
                ignored_seen++;
            end
        end
        ack_q     = o_ack;
        dbg_ack_q = o_dbg_ack;
    end

    // Starts and ends on a falling edge
    task automatic issue(input vec_t v);
        xlen_t   a;
        xlen_t   b;
        xlen_t   res;
        wb_exp_t e;
        i_instr <= v.instr;
        i_req   <= 1'b1;
        @(negedge i_clk);
        while (!o_ack) begin
            @(negedge i_clk);
        end
        e.rd     = v.instr.rd;
        e.is_mul = (v.instr.opcode == OP_MUL);
        e.due    = cycle + (e.is_mul ? MUL_LATENCY : 1);
        if (v.instr.rd != '0) begin
            issued_tag[v.instr.rd] = issued_tag[v.instr.rd] + 1'b1;
        end
        e.tag = issued_tag[v.instr.rd];
        if (e.is_mul) begin
            mul_q.push_back(e);
        end else begin
            alu_q.push_back(e);
        end
        a = shadow[v.instr.rs1];
        b = shadow[v.instr.rs2];
        case (v.instr.opcode)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_XOR:  res = a ^ b;
            default: res = a * b;                   // Low word only
        endcase
        if (v.instr.rd != '0) begin
            shadow[v.instr.rd] = res;
        end
        i_req <= 1'b0;
        @(negedge i_clk);
        while (o_ack) begin
            @(negedge i_clk);
        end
    endtask

    task automatic dbg_access(input reg_addr_t addr, input logic write, input xlen_t wdata,
                              output xlen_t rdata);
        i_dbg     <= {addr, write, wdata};
        i_dbg_req <= 1'b1;
        @(negedge i_clk);
        while (!o_dbg_ack) begin
            @(negedge i_clk);
        end
        rdata = o_dbg_rdata;
        i_dbg_req <= 1'b0;
        @(negedge i_clk);
        while (o_dbg_ack) begin
            @(negedge i_clk);
        end
    endtask

    task automatic check_all_regs();
        xlen_t got;
        for (int r = 0; r < NREGS; r++) begin
            dbg_access(reg_addr_t'(r), 1'b0, '0, got);
            if (got !== shadow[r]) begin
                report_mismatch($sformatf("o_dbg_rdata x%0d", r), shadow[r], got);
            end
        end
    endtask

    initial begin
        int        errs_start;
        vec_t      v;
        vec_t      nxt;
        reg_addr_t addr;
        xlen_t     got;
        i_nrst    = 1'b0;
        i_req     = 1'b0;
        i_instr   = '0;
        i_dbg_req = 1'b0;
        i_dbg     = '0;
        cycle        = 0;
        err_count    = 0;
        hs_errs      = 0;
        ignored_seen = 0;
        tests_run    = 0;
        tests_failed = 0;
        ack_q        = 1'b0;
        dbg_ack_q    = 1'b0;
        rng          = 32'd7;
        for (int r = 0; r < NREGS; r++) begin
            shadow[r]     = '0;
            issued_tag[r] = '0;
            stored_tag[r] = '0;
        end
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_nrst <= 1'b1;

        errs_start = err_count;
        @(negedge i_clk);
        if (o_ack !== 1'b0) begin
            report_mismatch("o_ack", 0, o_ack);
        end
        if (o_dbg_ack !== 1'b0) begin
            report_mismatch("o_dbg_ack", 0, o_dbg_ack);
        end
        if (o_wb_valid !== 1'b0) begin
            report_mismatch("o_wb_valid", 0, o_wb_valid);
        end
        check_all_regs();
        finish_test(1, "reset state", err_count - errs_start);

        errs_start = err_count;
        for (int i = 0; i < N_SEEDS; i++) begin
            addr = seed_addr(i);
            rng  = xorshift(rng);
            dbg_access(addr, 1'b1, rng, got);
            if (addr != '0) begin
                shadow[addr] = rng;                 // x0 keeps zero
            end
        end
        for (int i = 0; i < N_SEEDS; i++) begin
            addr = seed_addr(i);
            dbg_access(addr, 1'b0, '0, got);
            if (got !== shadow[addr]) begin
                report_mismatch($sformatf("o_dbg_rdata x%0d", addr), shadow[addr], got);
            end
        end
        finish_test(2, "debug write and read", err_count - errs_start);

        errs_start = err_count;
        for (int i = 0; i < N_PROG; i++) begin
            v   = prog_entry(i);
            nxt = (i < N_PROG - 1) ? prog_entry(i + 1) : '0;   // Test 0 marks the end
            issue(v);
            if (nxt.test != v.test) begin
                while ((alu_q.size() > 0) || (mul_q.size() > 0)) begin
                    @(negedge i_clk);
                end
                check_all_regs();
                if ((v.test == 3'd5) && (ignored_seen == 0)) begin
                    report_failure("no multiply write-back was dropped as ignored");
                end
                finish_test(v.test, test_name(v.test), err_count - errs_start);
                errs_start = err_count;
            end
        end
        finish_test(6, "four-phase handshakes", hs_errs);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/dbg_bridge.sv ====
// Debug bridge turning a four-phase request into a single bank access cycle
`timescale 1ns/100ps
`default_nettype none

module dbg_bridge (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_req,
    input  rf_pkg::dbg_req_t  i_dbg,            // Held while i_req is high
    input  rf_pkg::xlen_t     i_rdata,          // Bank debug read data
    output logic              o_ack,
    output rf_pkg::xlen_t     o_rdata,
    output rf_pkg::reg_addr_t o_addr,
    output logic              o_ena,
    output logic              o_write,
    output rf_pkg::xlen_t     o_wdata
);
    import rf_pkg::*;

    dbg_state_e state;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= DBG_IDLE;
        end else begin
            case (state)
                DBG_IDLE:   if (i_req) state <= DBG_ACCESS;
                DBG_ACCESS: state <= DBG_DONE;
                DBG_DONE:   if (!i_req) state <= DBG_IDLE;  // Wait for request to drop
                default:    state <= DBG_IDLE;
            endcase
        end
    end

    // Read data sampled in the access cycle, held through the acknowledge
    always_ff @(posedge i_clk) begin
        if (state == DBG_ACCESS) begin
            o_rdata <= i_rdata;
        end
    end

    assign o_ack   = (state == DBG_DONE);
    assign o_ena   = (state == DBG_ACCESS);
    assign o_addr  = i_dbg.addr;
    assign o_write = i_dbg.write;
    assign o_wdata = i_dbg.wdata;

endmodule

`default_nettype wire

// ==== logic/exec_stage.sv ====
// Execute stage with a one-cycle ALU and a multi-cycle multiply pipe sharing one write-back
`timescale 1ns/100ps
`default_nettype none

module exec_stage #(
    parameter int MUL_LATENCY = 6
) (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  rf_pkg::exec_req_t i_exec,
    output rf_pkg::wb_t       o_wb
);
    import rf_pkg::*;

    wb_t   alu_wb;
    wb_t   mul_pipe [MUL_LATENCY];              // One entry per multiply cycle
    xlen_t alu_res;
    xlen_t mul_lo;
    logic  is_mul;

    always_comb begin
        is_mul = (i_exec.opcode == OP_MUL);
        mul_lo = i_exec.a * i_exec.b;           // Low word of the product
        case (i_exec.opcode)
            OP_ADD:  alu_res = i_exec.a + i_exec.b;
            OP_SUB:  alu_res = i_exec.a - i_exec.b;
            OP_XOR:  alu_res = i_exec.a ^ i_exec.b;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            alu_wb <= '0;
            for (int k = 0; k < MUL_LATENCY; k++) begin
                mul_pipe[k] <= '0;
            end
        end else begin
            // ALU writes land unconditionally
            alu_wb <= '{valid:   i_exec.valid && !is_mul,
                        rd:      i_exec.rd,
                        tag:     i_exec.tag,
                        data:    alu_res,
                        inorder: 1'b0};
            mul_pipe[0] <= '{valid:   i_exec.valid && is_mul,
                             rd:      i_exec.rd,
                             tag:     i_exec.tag,
                             data:    mul_lo,
                             inorder: 1'b1};
            for (int k = 1; k < MUL_LATENCY; k++) begin
                mul_pipe[k] <= mul_pipe[k-1];
            end
        end
    end

    // Issue keeps the two paths from finishing in the same cycle
    assign o_wb = alu_wb.valid ? alu_wb : mul_pipe[MUL_LATENCY-1];

endmodule

`default_nettype wire

// ==== logic/int_reg_bank.sv ====
// Integer register bank holding value and tag pairs with sequenced write-back and a debug port
`timescale 1ns/100ps
`default_nettype none

module int_reg_bank (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  rf_pkg::reg_addr_t i_radr1,          // Read port 1 address
    input  rf_pkg::reg_addr_t i_radr2,          // Read port 2 address
    input  rf_pkg::wb_t       i_wb,             // Write-back from execute
    input  rf_pkg::reg_addr_t i_dbg_addr,
    input  logic              i_dbg_ena,
    input  logic              i_dbg_write,
    input  rf_pkg::xlen_t     i_dbg_wdata,
    output rf_pkg::xlen_t     o_rdata1,
    output rf_pkg::xlen_t     o_rdata2,
    output rf_pkg::reg_tag_t  o_rtag1,
    output rf_pkg::reg_tag_t  o_rtag2,
    output rf_pkg::xlen_t     o_dbg_rdata,
    output logic              o_ignored         // Sequenced write dropped this cycle
);
    import rf_pkg::*;

    xlen_t    vals [NREGS];
    reg_tag_t tags [NREGS];

    reg_tag_t next_tag;
    logic     wb_hit;
    logic     wb_inseq;
    logic     core_we;
    logic     dbg_we;

    always_comb begin
        next_tag = tags[i_wb.rd] + 1'b1;
        wb_inseq = (next_tag == i_wb.tag);
        wb_hit   = i_wb.valid && (i_wb.rd != '0);   // x0 never written
        core_we  = wb_hit && (!i_wb.inorder || wb_inseq);
        // Debug write only fills a cycle the core leaves free
        dbg_we   = i_dbg_ena && i_dbg_write && (i_dbg_addr != '0) && !core_we;
    end

    // A younger ALU write already moved the tag past this multiply
    assign o_ignored = wb_hit && i_wb.inorder && !wb_inseq;

    // Asynchronous reads, x0 pinned at zero
    assign o_rdata1    = (i_radr1 == '0) ? '0 : vals[i_radr1];
    assign o_rdata2    = (i_radr2 == '0) ? '0 : vals[i_radr2];
    assign o_rtag1     = tags[i_radr1];
    assign o_rtag2     = tags[i_radr2];
    assign o_dbg_rdata = (i_dbg_addr == '0) ? '0 : vals[i_dbg_addr];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < NREGS; i++) begin
                vals[i] <= '0;
                tags[i] <= '0;
            end
        end else if (core_we) begin
            vals[i_wb.rd] <= i_wb.data;
            tags[i_wb.rd] <= i_wb.tag;
        end else if (dbg_we) begin
            vals[i_dbg_addr] <= i_dbg_wdata;        // Tag stays as it was
        end
    end

endmodule

`default_nettype wire

// ==== logic/issue_stage.sv ====
// Issue stage taking instructions over a four-phase handshake, allocating tags and stalling on hazards
`timescale 1ns/100ps
`default_nettype none

module issue_stage #(
    parameter int MUL_LATENCY = 6
) (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_req,
    input  rf_pkg::instr_t    i_instr,          // Held stable while i_req is high
    input  rf_pkg::xlen_t     i_rdata1,
    input  rf_pkg::xlen_t     i_rdata2,
    input  rf_pkg::reg_tag_t  i_rtag1,
    input  rf_pkg::reg_tag_t  i_rtag2,
    output logic              o_ack,
    output rf_pkg::reg_addr_t o_radr1,
    output rf_pkg::reg_addr_t o_radr2,
    output rf_pkg::exec_req_t o_exec
);
    import rf_pkg::*;

    issue_state_e           state;
    reg_tag_t               issued [NREGS];     // Last tag handed out per register
    logic [MUL_LATENCY-1:1] mul_hist;           // Bit k set when a multiply issued k cycles ago

    logic     is_mul;
    logic     src1_busy;
    logic     src2_busy;
    logic     mul_clash;
    logic     hazard;
    logic     accept;
    reg_tag_t new_tag;

    assign o_radr1 = i_instr.rs1;
    assign o_radr2 = i_instr.rs2;
    assign o_ack   = (state == IS_WAIT_DROP);

    always_comb begin
        is_mul    = (i_instr.opcode == OP_MUL);
        // Source pending while the bank has not caught up with its last issued tag
        src1_busy = (i_instr.rs1 != '0) && (issued[i_instr.rs1] != i_rtag1);
        src2_busy = (i_instr.rs2 != '0) && (issued[i_instr.rs2] != i_rtag2);
        mul_clash = !is_mul && mul_hist[MUL_LATENCY-1]; // Would share the write-back slot
        hazard    = src1_busy || src2_busy || mul_clash;
        accept    = i_req && (state == IS_IDLE) && !hazard;
        new_tag   = issued[i_instr.rd] + 1'b1;
    end

    // Four-phase handshake
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= IS_IDLE;
        end else begin
            case (state)
                IS_IDLE:      if (accept) state <= IS_WAIT_DROP;
                IS_WAIT_DROP: if (!i_req) state <= IS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < NREGS; i++) begin
                issued[i] <= '0;
            end
            mul_hist <= '0;
        end else begin
            mul_hist[1] <= accept && is_mul;
            for (int k = 2; k < MUL_LATENCY; k++) begin
                mul_hist[k] <= mul_hist[k-1];
            end
            if (accept && (i_instr.rd != '0)) begin
                issued[i_instr.rd] <= new_tag;
            end
        end
    end

    // Operands captured at acceptance, valid for one cycle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_exec <= '0;
        end else begin
            o_exec.valid <= accept;
            if (accept) begin
                o_exec.opcode <= i_instr.opcode;
                o_exec.rd     <= i_instr.rd;
                o_exec.tag    <= new_tag;
                o_exec.a      <= i_rdata1;
                o_exec.b      <= i_rdata2;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/rf_core.sv ====
// Register subsystem top joining issue, execute, the tagged bank and the debug bridge
`timescale 1ns/100ps
`default_nettype none

module rf_core #(
    parameter int MUL_LATENCY = 6               // Multiply latency, 2 to 8
) (
    input  logic              i_clk,
    input  logic              i_nrst,
    input  logic              i_req,
    input  rf_pkg::instr_t    i_instr,
    input  logic              i_dbg_req,
    input  rf_pkg::dbg_req_t  i_dbg,
    output logic              o_ack,
    output logic              o_dbg_ack,
    output rf_pkg::xlen_t     o_dbg_rdata,
    output logic              o_wb_valid,
    output rf_pkg::reg_addr_t o_wb_rd,
    output logic              o_wb_ignored
);
    import rf_pkg::*;

    exec_req_t exec_req;
    wb_t       wb;

    reg_addr_t radr1;
    reg_addr_t radr2;
    xlen_t     rdata1;
    xlen_t     rdata2;
    reg_tag_t  rtag1;
    reg_tag_t  rtag2;

    // Bridge to bank debug port
    reg_addr_t dbg_addr;
    logic      dbg_ena;
    logic      dbg_write;
    xlen_t     dbg_wdata;
    xlen_t     dbg_rdata;

    issue_stage #(
        .MUL_LATENCY(MUL_LATENCY)
    ) u_issue (
        .i_clk    (i_clk),
        .i_nrst   (i_nrst),
        .i_req    (i_req),
        .i_instr  (i_instr),
        .i_rdata1 (rdata1),
        .i_rdata2 (rdata2),
        .i_rtag1  (rtag1),
        .i_rtag2  (rtag2),
        .o_ack    (o_ack),
        .o_radr1  (radr1),
        .o_radr2  (radr2),
        .o_exec   (exec_req)
    );

    exec_stage #(
        .MUL_LATENCY(MUL_LATENCY)
    ) u_exec (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_exec (exec_req),
        .o_wb   (wb)
    );

    int_reg_bank u_bank (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_radr1     (radr1),
        .i_radr2     (radr2),
        .i_wb        (wb),
        .i_dbg_addr  (dbg_addr),
        .i_dbg_ena   (dbg_ena),
        .i_dbg_write (dbg_write),
        .i_dbg_wdata (dbg_wdata),
        .o_rdata1    (rdata1),
        .o_rdata2    (rdata2),
        .o_rtag1     (rtag1),
        .o_rtag2     (rtag2),
        .o_dbg_rdata (dbg_rdata),
        .o_ignored   (o_wb_ignored)
    );

    dbg_bridge u_dbg (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_req   (i_dbg_req),
        .i_dbg   (i_dbg),
        .i_rdata (dbg_rdata),
        .o_ack   (o_dbg_ack),
        .o_rdata (o_dbg_rdata),
        .o_addr  (dbg_addr),
        .o_ena   (dbg_ena),
        .o_write (dbg_write),
        .o_wdata (dbg_wdata)
    );

    assign o_wb_valid = wb.valid;
    assign o_wb_rd    = wb.rd;

endmodule

`default_nettype wire

// ==== logic/rf_pkg.sv ====
// Register subsystem package with widths, operation codes, bus structs and FSM states
`default_nettype none

package rf_pkg;

    localparam int XLEN  = 32;
    localparam int TAG_W = 3;                   // Tags wrap around
    localparam int NREGS = 32;

    typedef logic [XLEN-1:0]          xlen_t;
    typedef logic [$clog2(NREGS)-1:0] reg_addr_t;
    typedef logic [TAG_W-1:0]         reg_tag_t;
    typedef logic [1:0]               opcode_t;

    localparam opcode_t OP_ADD = 2'd0;
    localparam opcode_t OP_SUB = 2'd1;
    localparam opcode_t OP_XOR = 2'd2;
    localparam opcode_t OP_MUL = 2'd3;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
    } instr_t;

    // Issue to execute, one cycle per instruction
    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        reg_addr_t rd;
        reg_tag_t  tag;
        xlen_t     a;
        xlen_t     b;
    } exec_req_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        reg_tag_t  tag;
        xlen_t     data;
        logic      inorder;                     // Write only if tag is next in sequence
    } wb_t;

    typedef struct packed {
        reg_addr_t addr;
        logic      write;
        xlen_t     wdata;
    } dbg_req_t;

    typedef enum logic {
        IS_IDLE,
        IS_WAIT_DROP
    } issue_state_e;

    typedef enum logic [1:0] {
        DBG_IDLE,
        DBG_ACCESS,
        DBG_DONE
    } dbg_state_e;

endpackage

`default_nettype wire

// ==== project.f ====
+incdir+dv
logic/rf_pkg.sv
logic/int_reg_bank.sv
logic/issue_stage.sv
logic/exec_stage.sv
logic/dbg_bridge.sv
logic/rf_core.sv
dv/rf_core_tb.sv
